/* bench/clk_gen.sv */
`default_nettype none

module clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // released mid cycle
  end

endmodule

`default_nettype wire

/* bench/tb_core.sv */
`default_nettype none

`include "core_consts.svh"

module tb_core import core_pkg::*; ();

  localparam int NUM_INSTS      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * 3 + 20;
  localparam int DRIVE_DLY      = 2;

  logic        clk;
  logic        rst_n;
  logic        inst_valid;
  xlen_t       inst_addr;
  inst_t       inst_data;
  logic        stall;
  logic        wb_en;
  reg_idx_t    wb_idx;
  xlen_t       wb_data;
  logic        redirect_valid;
  xlen_t       redirect_addr;
  logic        trap_valid;
  xlen_t       trap_addr;
  inst_t       trap_inst;
  logic [31:0] lfsr_state = 32'h26b4_3be7;
  xlen_t       model_regs [0:31];

  clk_gen #(.PERIOD(40), .RESET_CYCLES(3)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  core_id_ex_top UUT (
    .clk              (clk),
    .rst_n_i          (rst_n),
    .inst_valid_i     (inst_valid),
    .inst_addr_i      (inst_addr),
    .inst_data_i      (inst_data),
    .stall_i          (stall),
    .wb_en_o          (wb_en),
    .wb_idx_o         (wb_idx),
    .wb_data_o        (wb_data),
    .redirect_valid_o (redirect_valid),
    .redirect_addr_o  (redirect_addr),
    .trap_valid_o     (trap_valid),
    .trap_addr_o      (trap_addr),
    .trap_inst_o      (trap_inst)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic reg_idx_t rand_reg();
    logic [31:0] v;
    v = (rand_bits(2) != 0) ? rand_bits(3) : rand_bits(5);  // mostly x0..x7 for frequent hazards
    return v[4:0];
  endfunction

  function automatic inst_t make_inst();
    logic [31:0] kind;
    logic [31:0] r;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    kind = rand_bits(4);
    r    = rand_bits(25);  // immediate filler
    rd   = rand_reg();
    rs1  = rand_reg();
    rs2  = rand_reg();
    case (kind)
      0, 1, 2, 3, 4: begin
        case (rand_bits(3))
          1:       return {7'b0100000, rs2, rs1, 3'b000, rd, `OPCODE_OP};  // sub
          2:       return {7'b0000000, rs2, rs1, 3'b111, rd, `OPCODE_OP};
          3:       return {7'b0000000, rs2, rs1, 3'b110, rd, `OPCODE_OP};
          4:       return {7'b0000000, rs2, rs1, 3'b100, rd, `OPCODE_OP};
          5, 6:    return {7'b0000000, rs2, rs1, 3'b010, rd, `OPCODE_OP};  // slt
          default: return {7'b0000000, rs2, rs1, 3'b000, rd, `OPCODE_OP};
        endcase
      end
      10:     return {r[19:0], rd, `OPCODE_LUI};
      11, 12: return {r[6:0], rs2, rs1, 2'b00, r[7], r[12:8], `OPCODE_BRANCH};  // beq or bne
      13:     return {r[19:0], rd, `OPCODE_JAL};
      14: begin
        case (rand_bits(2))
          0:       return {r[24:0], 7'b0000011};  // load
          1:       return {7'b0000001, rs2, rs1, r[2:0], rd, `OPCODE_OP};
          2:       return {r[11:0], rs1, 3'b010, rd, `OPCODE_OP_IMM};  // slti
          default: return {r[6:0], rs2, rs1, 3'b100, r[11:7], `OPCODE_BRANCH};
        endcase
      end
      default: begin
        case (rand_bits(2))
          0:       return {r[11:0], rs1, 3'b000, rd, `OPCODE_OP_IMM};
          1:       return {r[11:0], rs1, 3'b111, rd, `OPCODE_OP_IMM};
          2:       return {r[11:0], rs1, 3'b110, rd, `OPCODE_OP_IMM};
          default: return {r[11:0], rs1, 3'b100, rd, `OPCODE_OP_IMM};
        endcase
      end
    endcase
  endfunction

  // RV32I subset against the register state at retirement
  task automatic predict(input inst_t inst, input xlen_t pc, output logic wen,
                         output xlen_t wdata, output logic redir, output xlen_t target,
                         output logic trap);
    xlen_t a;
    xlen_t b;
    xlen_t imm;
    a      = model_regs[inst[19:15]];
    b      = model_regs[inst[24:20]];
    imm    = {{21{inst[31]}}, inst[30:20]};
    wen    = 1'b1;
    wdata  = '0;
    redir  = 1'b0;
    target = '0;
    trap   = 1'b0;
    case (inst[6:0])
      `OPCODE_OP: begin
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: wdata = a + b;
          10'b0100000_000: wdata = a - b;
          10'b0000000_111: wdata = a & b;
          10'b0000000_110: wdata = a | b;
          10'b0000000_100: wdata = a ^ b;
          10'b0000000_010: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:         trap = 1'b1;
        endcase
      end
      `OPCODE_OP_IMM: begin
        case (inst[14:12])
          3'b000:  wdata = a + imm;
          3'b111:  wdata = a & imm;
          3'b110:  wdata = a | imm;
          3'b100:  wdata = a ^ imm;
          default: trap = 1'b1;
        endcase
      end
      `OPCODE_LUI: wdata = {inst[31:12], 12'h000};
      `OPCODE_BRANCH: begin
        wen    = 1'b0;
        target = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        case (inst[14:12])
          3'b000:  redir = (a == b);
          3'b001:  redir = (a != b);
          default: trap = 1'b1;
        endcase
      end
      `OPCODE_JAL: begin
        wdata  = pc + 32'd4;
        redir  = 1'b1;
        target = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: trap = 1'b1;
    endcase
    if (trap || inst[11:7] == 5'd0) begin
      wen = 1'b0;  // x0 and traps write nothing
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  initial begin : stimulus
    logic  hold;
    logic  ex_valid;
    xlen_t ex_pc;
    inst_t ex_inst;
    logic  wen;
    logic  redir;
    logic  trap;
    xlen_t wdata;
    xlen_t target;
    xlen_t fetch_pc;
    int    issued;
    inst_valid = 1'b0;
    inst_addr  = '0;
    inst_data  = `INST_NOP;
    stall      = 1'b0;
    hold       = 1'b0;
    ex_valid   = 1'b0;
    ex_pc      = '0;
    ex_inst    = `INST_NOP;
    fetch_pc   = 32'h0000_1000;
    issued     = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    wait (rst_n === 1'b1);
    while (issued < NUM_INSTS || ex_valid) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (!hold) begin
        inst_valid = (issued < NUM_INSTS) && (rand_bits(3) != 0);  // about one gap in eight
        inst_data  = make_inst();
        inst_addr  = fetch_pc;
        fetch_pc   = inst_valid ? fetch_pc + 32'd4 : fetch_pc;
      end
      stall = (rand_bits(3) == 0);
      @(negedge clk);
      wen   = 1'b0;
      redir = 1'b0;
      trap  = 1'b0;
      if (ex_valid && !stall) begin
        predict(ex_inst, ex_pc, wen, wdata, redir, target, trap);
      end
      check_eq("wb_en_o", wb_en, wen);
      check_eq("redirect_valid_o", redirect_valid, redir);
      check_eq("trap_valid_o", trap_valid, trap);
      if (wen) begin
        check_eq("wb_idx_o", wb_idx, ex_inst[11:7]);
        check_eq("wb_data_o", wb_data, wdata);
        model_regs[ex_inst[11:7]] = wdata;
      end
      if (redir) begin
        check_eq("redirect_addr_o", redirect_addr, target);
        fetch_pc = target;
      end
      if (trap) begin
        check_eq("trap_addr_o", trap_addr, ex_pc);
        check_eq("trap_inst_o", trap_inst, ex_inst);
      end
      hold = stall;  // decode slot not consumed yet
      if (!stall) begin
        issued   = inst_valid ? issued + 1 : issued;
        ex_valid = inst_valid && !redir;  // taken branch kills the decode slot
        ex_pc    = inst_addr;
        ex_inst  = inst_data;
      end
    end
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* rtl/alu_exec.sv */
`default_nettype none

`include "core_consts.svh"

module alu_exec import core_pkg::*; (
  input  logic     stall_i,
  id_ex_if.dst     ex,
  output logic     wb_en_o,
  output reg_idx_t wb_idx_o,
  output xlen_t    wb_data_o,
  output logic     flush_o,
  output logic     redirect_valid_o,
  output xlen_t    redirect_addr_o,
  output logic     trap_valid_o,
  output xlen_t    trap_addr_o,
  output inst_t    trap_inst_o
);

  logic  retire;
  logic  taken;
  logic  writes_rd;
  xlen_t op_b;
  xlen_t alu_res;

  assign retire = ex.valid & ~stall_i;

  // r-type takes rs2, everything else the immediate
  assign op_b = (ex.inst[6:0] == `OPCODE_OP) ? ex.rs2_data : ex.imm;

  always_comb begin
    case (ex.alu_op)
      `ALUOP_ADD:      alu_res = ex.rs1_data + op_b;
      `ALUOP_SUB:      alu_res = ex.rs1_data - op_b;
      `ALUOP_AND:      alu_res = ex.rs1_data & op_b;
      `ALUOP_OR:       alu_res = ex.rs1_data | op_b;
      `ALUOP_XOR:      alu_res = ex.rs1_data ^ op_b;
      `ALUOP_SLT:      alu_res = {31'b0, $signed(ex.rs1_data) < $signed(op_b)};
      `ALUOP_PASS_IMM: alu_res = op_b;
      default:         alu_res = '0;
    endcase
  end

  always_comb begin
    case (ex.pc_op)
      `PCOP_BEQ: taken = (ex.rs1_data == ex.rs2_data);
      `PCOP_BNE: taken = (ex.rs1_data != ex.rs2_data);
      `PCOP_JAL: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  // branches have no destination
  assign writes_rd = (ex.pc_op == `PCOP_NONE) || (ex.pc_op == `PCOP_JAL);

  assign wb_en_o   = retire & ~ex.illegal & writes_rd & (ex.rd_idx != '0);
  assign wb_idx_o  = ex.rd_idx;
  assign wb_data_o = (ex.pc_op == `PCOP_JAL) ? ex.pc + 32'd4 : alu_res;  // link address

  assign redirect_valid_o = retire & ~ex.illegal & taken;
  assign redirect_addr_o  = ex.pc + ex.imm;
  assign flush_o          = redirect_valid_o;  // kills the word sitting in decode

  assign trap_valid_o = retire & ex.illegal;
  assign trap_addr_o  = ex.pc;
  assign trap_inst_o  = ex.inst;

endmodule

`default_nettype wire

/* rtl/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define XLEN           32
`define REG_ADDRWIDTH  5
`define INST_LEN       32
`define IMM_LEN        32
`define ALUOP_LEN      4
`define PCOP_LEN       2

`define INST_NOP       32'h0000_0013  // addi x0, x0, 0

`define ALUOP_NONE     4'd0
`define ALUOP_ADD      4'd1
`define ALUOP_SUB      4'd2
`define ALUOP_AND      4'd3
`define ALUOP_OR       4'd4
`define ALUOP_XOR      4'd5
`define ALUOP_SLT      4'd6
`define ALUOP_PASS_IMM 4'd7  // lui

`define PCOP_NONE      2'd0
`define PCOP_BEQ       2'd1
`define PCOP_BNE       2'd2
`define PCOP_JAL       2'd3

`define OPCODE_OP      7'b0110011
`define OPCODE_OP_IMM  7'b0010011
`define OPCODE_LUI     7'b0110111
`define OPCODE_BRANCH  7'b1100011
`define OPCODE_JAL     7'b1101111

`define FUNCT3_ADD     3'b000
`define FUNCT3_SLT     3'b010
`define FUNCT3_XOR     3'b100
`define FUNCT3_OR      3'b110
`define FUNCT3_AND     3'b111
`define FUNCT3_BEQ     3'b000
`define FUNCT3_BNE     3'b001

`define FUNCT7_BASE    7'b0000000
`define FUNCT7_ALT     7'b0100000  // sub

`endif

/* rtl/core_id_ex_top.sv */
`default_nettype none

module core_id_ex_top import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     inst_valid_i,
  input  xlen_t    inst_addr_i,
  input  inst_t    inst_data_i,
  input  logic     stall_i,
  output logic     wb_en_o,
  output reg_idx_t wb_idx_o,
  output xlen_t    wb_data_o,
  output logic     redirect_valid_o,
  output xlen_t    redirect_addr_o,
  output logic     trap_valid_o,
  output xlen_t    trap_addr_o,
  output inst_t    trap_inst_o
);

  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  logic     wb_en;
  reg_idx_t wb_idx;
  xlen_t    wb_data;
  logic     flush;

  id_ex_if dec_bus ();
  id_ex_if ex_bus ();

  reg_file u_reg_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wb_en_i    (wb_en),
    .wb_idx_i   (wb_idx),
    .wb_data_i  (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  inst_decode u_inst_decode (
    .inst_valid_i (inst_valid_i),
    .inst_addr_i  (inst_addr_i),
    .inst_data_i  (inst_data_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .dec          (dec_bus.src)
  );

  id_ex u_id_ex (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .flush_i (flush),
    .dec     (dec_bus.dst),
    .ex      (ex_bus.src)
  );

  alu_exec u_alu_exec (
    .stall_i          (stall_i),
    .ex               (ex_bus.dst),
    .wb_en_o          (wb_en),
    .wb_idx_o         (wb_idx),
    .wb_data_o        (wb_data),
    .flush_o          (flush),
    .redirect_valid_o (redirect_valid_o),
    .redirect_addr_o  (redirect_addr_o),
    .trap_valid_o     (trap_valid_o),
    .trap_addr_o      (trap_addr_o),
    .trap_inst_o      (trap_inst_o)
  );

  assign wb_en_o   = wb_en;
  assign wb_idx_o  = wb_idx;
  assign wb_data_o = wb_data;

endmodule

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

`include "core_consts.svh"

package core_pkg;

  // data word
  typedef logic [`XLEN-1:0] xlen_t;

  // raw instruction bits
  typedef logic [`INST_LEN-1:0] inst_t;

  // architectural register index
  typedef logic [`REG_ADDRWIDTH-1:0] reg_idx_t;

  // alu operation select
  typedef logic [`ALUOP_LEN-1:0] alu_op_t;

  // control flow operation select
  typedef logic [`PCOP_LEN-1:0] pc_op_t;

endpackage

`default_nettype wire

/* rtl/id_ex.sv */
`default_nettype none

`include "core_consts.svh"

module id_ex (
  input  logic clk,
  input  logic rst_n_i,
  input  logic stall_i,
  input  logic flush_i,   // only ever high with stall_i low
  id_ex_if.dst dec,
  id_ex_if.src ex
);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex.valid    <= 1'b0;
      ex.pc       <= '0;
      ex.inst     <= `INST_NOP;
      ex.rs1_data <= '0;
      ex.rs2_data <= '0;
      ex.rd_idx   <= '0;
      ex.imm      <= '0;
      ex.alu_op   <= `ALUOP_NONE;
      ex.pc_op    <= `PCOP_NONE;
      ex.illegal  <= 1'b0;
    end else if (flush_i) begin
      // drop the decode slot, insert a bubble
      ex.valid    <= 1'b0;
      ex.pc       <= '0;
      ex.inst     <= `INST_NOP;
      ex.rs1_data <= '0;
      ex.rs2_data <= '0;
      ex.rd_idx   <= '0;
      ex.imm      <= '0;
      ex.alu_op   <= `ALUOP_NONE;
      ex.pc_op    <= `PCOP_NONE;
      ex.illegal  <= 1'b0;
    end else if (!stall_i) begin
      ex.valid    <= dec.valid;
      ex.pc       <= dec.pc;
      ex.inst     <= dec.inst;
      ex.rs1_data <= dec.rs1_data;
      ex.rs2_data <= dec.rs2_data;
      ex.rd_idx   <= dec.rd_idx;
      ex.imm      <= dec.imm;
      ex.alu_op   <= dec.alu_op;
      ex.pc_op    <= dec.pc_op;
      ex.illegal  <= dec.illegal;
    end
  end

endmodule

`default_nettype wire

/* rtl/id_ex_if.sv */
`default_nettype none

`include "core_consts.svh"

interface id_ex_if import core_pkg::*; ();

  logic               valid;     // plain level, no handshake
  xlen_t              pc;
  inst_t              inst;
  xlen_t              rs1_data;
  xlen_t              rs2_data;
  reg_idx_t           rd_idx;
  logic [`IMM_LEN-1:0] imm;       // already sign extended
  alu_op_t            alu_op;
  pc_op_t             pc_op;
  logic               illegal;

  modport src (
    output valid,
    output pc,
    output inst,
    output rs1_data,
    output rs2_data,
    output rd_idx,
    output imm,
    output alu_op,
    output pc_op,
    output illegal
  );

  modport dst (
    input valid,
    input pc,
    input inst,
    input rs1_data,
    input rs2_data,
    input rd_idx,
    input imm,
    input alu_op,
    input pc_op,
    input illegal
  );

endinterface

`default_nettype wire

/* rtl/inst_decode.sv */
`default_nettype none

`include "core_consts.svh"

module inst_decode import core_pkg::*; (
  input  logic     inst_valid_i,
  input  xlen_t    inst_addr_i,
  input  inst_t    inst_data_i,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  output reg_idx_t rs1_idx_o,
  output reg_idx_t rs2_idx_o,
  id_ex_if.src     dec
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`IMM_LEN-1:0] imm_i;
  logic [`IMM_LEN-1:0] imm_u;
  logic [`IMM_LEN-1:0] imm_b;
  logic [`IMM_LEN-1:0] imm_j;
  logic [`IMM_LEN-1:0] imm;
  alu_op_t             alu_op;
  pc_op_t              pc_op;
  logic                illegal;

  assign opcode = inst_data_i[6:0];
  assign funct3 = inst_data_i[14:12];
  assign funct7 = inst_data_i[31:25];

  assign rs1_idx_o = inst_data_i[19:15];
  assign rs2_idx_o = inst_data_i[24:20];  // don't care outside r-type and branches

  assign imm_i = {{20{inst_data_i[31]}}, inst_data_i[31:20]};
  assign imm_u = {inst_data_i[31:12], 12'b0};
  assign imm_b = {{19{inst_data_i[31]}}, inst_data_i[31], inst_data_i[7],
                  inst_data_i[30:25], inst_data_i[11:8], 1'b0};
  assign imm_j = {{11{inst_data_i[31]}}, inst_data_i[31], inst_data_i[19:12],
                  inst_data_i[20], inst_data_i[30:21], 1'b0};

  always_comb begin
    alu_op  = `ALUOP_NONE;
    pc_op   = `PCOP_NONE;
    illegal = 1'b0;
    imm     = '0;
    case (opcode)
      `OPCODE_OP: begin
        case ({funct7, funct3})
          {`FUNCT7_BASE, `FUNCT3_ADD}: alu_op = `ALUOP_ADD;
          {`FUNCT7_ALT,  `FUNCT3_ADD}: alu_op = `ALUOP_SUB;
          {`FUNCT7_BASE, `FUNCT3_AND}: alu_op = `ALUOP_AND;
          {`FUNCT7_BASE, `FUNCT3_OR}:  alu_op = `ALUOP_OR;
          {`FUNCT7_BASE, `FUNCT3_XOR}: alu_op = `ALUOP_XOR;
          {`FUNCT7_BASE, `FUNCT3_SLT}: alu_op = `ALUOP_SLT;
          default:                     illegal = 1'b1;
        endcase
      end
      `OPCODE_OP_IMM: begin
        imm = imm_i;
        case (funct3)
          `FUNCT3_ADD: alu_op = `ALUOP_ADD;
          `FUNCT3_AND: alu_op = `ALUOP_AND;
          `FUNCT3_OR:  alu_op = `ALUOP_OR;
          `FUNCT3_XOR: alu_op = `ALUOP_XOR;
          default:     illegal = 1'b1;  // slti and shifts not supported
        endcase
      end
      `OPCODE_LUI: begin
        imm    = imm_u;
        alu_op = `ALUOP_PASS_IMM;
      end
      `OPCODE_BRANCH: begin
        imm = imm_b;
        case (funct3)
          `FUNCT3_BEQ: pc_op = `PCOP_BEQ;
          `FUNCT3_BNE: pc_op = `PCOP_BNE;
          default:     illegal = 1'b1;
        endcase
      end
      `OPCODE_JAL: begin
        imm   = imm_j;
        pc_op = `PCOP_JAL;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  assign dec.valid    = inst_valid_i;
  assign dec.pc       = inst_addr_i;
  assign dec.inst     = inst_data_i;
  assign dec.rs1_data = rs1_data_i;
  assign dec.rs2_data = rs2_data_i;
  assign dec.rd_idx   = inst_data_i[11:7];
  assign dec.imm      = imm;
  assign dec.alu_op   = alu_op;
  assign dec.pc_op    = pc_op;
  assign dec.illegal  = illegal;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  input  logic     wb_en_i,
  input  reg_idx_t wb_idx_i,
  input  xlen_t    wb_data_i,
  output xlen_t    rs1_data_o,
  output xlen_t    rs2_data_o
);

  xlen_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && (wb_idx_i != '0)) begin
      regs[wb_idx_i] <= wb_data_i;
    end
  end

  // same-cycle write is forwarded to the reader
  function automatic xlen_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wb_en_i && (idx == wb_idx_i)) begin
      return wb_data_i;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_idx_i);
  end

  always_comb begin
    rs2_data_o = read_port(rs2_idx_i);
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/id_ex_if.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/id_ex.sv
rtl/alu_exec.sv
rtl/core_id_ex_top.sv
bench/clk_gen.sv
bench/tb_core.sv
